/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axi_reg_stream
FLAGS     ?= --binary -j 0
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the build directory"
	@echo "variables: VERILATOR, TOP, FLAGS, OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f verilog.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* common/issue_if.sv */
`timescale 1ns/1ps

interface issue_if import regstream_pkg::*; ();

   logic   push;
   data_t  push_data;
   logic   push_last;
   logic   status_rd;  // pulses when software reads the status register
   logic   failed;
   logic   empty;
   level_t level;

   modport bank (output push, push_data, push_last, status_rd,
                 input failed, empty, level);
   modport issuer (input push, push_data, push_last, status_rd,
                   output failed, empty, level);

endinterface

/* common/reg_bus_if.sv */
`timescale 1ns/1ps

interface reg_bus_if import regstream_pkg::*; #(
   parameter int REG_BITS = 10
) ();

   typedef logic [REG_BITS-1:0] regno_t;

   logic   wren;
   regno_t wreg_no;
   data_t  wdata;
   strb_t  wstrb;
   logic   rden;
   regno_t rreg_no;
   data_t  rdata;
   logic   err;

   function automatic logic wr_hit(input reg_sel_e sel);
      return wren && (wreg_no == regno_t'(sel));
   endfunction

   function automatic logic rd_hit(input reg_sel_e sel);
      return rden && (rreg_no == regno_t'(sel));
   endfunction

   // register numbers past the status register have nothing behind them
   function automatic logic mapped(input regno_t n);
      return n <= regno_t'(REG_STREAM_STATUS);
   endfunction

   function automatic data_t merge_bytes(input data_t old);
      data_t merged;
      for (int i = 0; i < $bits(strb_t); i++) begin
         merged[i*8 +: 8] = wstrb[i] ? wdata[i*8 +: 8] : old[i*8 +: 8];
      end
      return merged;
   endfunction

   modport server (output wren, wreg_no, wdata, wstrb, rden, rreg_no,
                   input rdata, err);
   modport client (import wr_hit, rd_hit, mapped, merge_bytes,
                   input wren, wreg_no, wdata, wstrb, rden, rreg_no,
                   output rdata, err);

endinterface

/* common/regstream_pkg.sv */
package regstream_pkg;

   typedef logic [31:0] data_t;
   typedef logic [3:0]  strb_t;
   typedef logic [7:0]  level_t;  // fill level field of the status register

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2
   } resp_e;

   // register numbers are the byte address divided by four
   typedef enum logic [2:0] {
      REG_ID            = 3'd0,
      REG_SCRATCH       = 3'd1,
      REG_CTRL          = 3'd2,
      REG_STREAM_DATA   = 3'd3,
      REG_STREAM_STATUS = 3'd4
   } reg_sel_e;

   localparam data_t ID_VALUE = 32'h5253_0001;

endpackage

/* test/tb_axi_reg_stream.sv */
`timescale 1ns/1ps

module tb_axi_reg_stream import regstream_pkg::*; ();

   localparam int          ADDR_WIDTH      = 12;
   localparam int          FIFO_DEPTH      = 4;
   localparam logic [31:0] SEED            = 32'h1fad_1433;
   localparam int          LONGEST_TEST_NS = 5000;  // the scratch strobe test with a wide margin
   localparam int          WATCHDOG_NS     = 4 * LONGEST_TEST_NS;
   localparam reg_sel_e    UNMAPPED_REG    = reg_sel_e'(3'd6);  // no register behind this number

   logic                  aximm = 1'b0;
   logic                  rst;
   logic [ADDR_WIDTH-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   data_t                 wdata;
   strb_t                 wstrb;
   logic                  wvalid;
   logic                  wready;
   logic                  bvalid;
   resp_e                 bresp;
   logic                  bready;
   logic [ADDR_WIDTH-1:0] araddr;
   logic                  arvalid;
   logic                  arready;
   logic                  rvalid;
   data_t                 rdata;
   resp_e                 rresp;
   logic                  rready;
   logic                  tvalid;
   data_t                 tdata;
   logic                  tlast;
   logic                  tready;

   logic [31:0] data_seed = SEED;
   logic [31:0] rdy_seed  = SEED;
   int          rdy_mode  = 0;  // 0 holds tready low, 1 follows the LCG, 2 holds it high
   data_t       rx_data[$];
   logic        rx_last[$];
   data_t       scratch_model;
   int          errors       = 0;
   int          tests        = 0;
   int          failed_tests = 0;

   axi_reg_stream_top #(.ADDR_WIDTH(ADDR_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

   always #4 aximm = ~aximm;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [ADDR_WIDTH-1:0] reg_addr(input reg_sel_e n);
      return ADDR_WIDTH'({n, 2'b00});
   endfunction

   function automatic data_t status_word(input logic failed, input logic empty, input level_t level);
      return {16'd0, level, 6'd0, empty, failed};
   endfunction

   task automatic check_data(input string what, input data_t got, input data_t exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_resp(input string what, input resp_e got, input resp_e exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic axi_write(input reg_sel_e n, input data_t data, input strb_t strb,
                            output resp_e resp);
      @(negedge aximm);
      awaddr  = reg_addr(n);
      wdata   = data;
      wstrb   = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge aximm);
      while (!awready && !wready) @(negedge aximm);
      check_flag("wready with awready", wready, awready);
      @(negedge aximm);  // valids stay up through the access cycle
      awvalid = 1'b0;
      wvalid  = 1'b0;
      while (!bvalid) @(negedge aximm);
      resp   = bresp;
      bready = 1'b1;
      @(negedge aximm);
      bready = 1'b0;
   endtask

   task automatic axi_read(input reg_sel_e n, output data_t data, output resp_e resp);
      @(negedge aximm);
      araddr  = reg_addr(n);
      arvalid = 1'b1;
      @(negedge aximm);
      while (!arready) @(negedge aximm);
      @(negedge aximm);
      arvalid = 1'b0;
      while (!rvalid) @(negedge aximm);
      data   = rdata;
      resp   = rresp;
      rready = 1'b1;
      @(negedge aximm);
      rready = 1'b0;
   endtask

   task automatic write_expect(input reg_sel_e n, input data_t data, input strb_t strb,
                               input resp_e exp);
      resp_e resp;
      axi_write(n, data, strb, resp);
      check_resp($sformatf("write response of reg %0d", n), resp, exp);
   endtask

   task automatic read_expect(input reg_sel_e n, input data_t exp, input resp_e exp_resp);
      data_t data;
      resp_e resp;
      axi_read(n, data, resp);
      check_data($sformatf("reg %0d", n), data, exp);
      check_resp($sformatf("read response of reg %0d", n), resp, exp_resp);
   endtask

   task automatic end_test(input string name, input int err_before);
      tests++;
      if (errors == err_before) begin
         $display("test %s: ok", name);
      end else begin
         failed_tests++;
         $display("test %s: %0d check(s) failed", name, errors - err_before);
      end
   endtask

   task automatic reset_and_id();
      int e;
      e = errors;
      check_flag("tvalid after reset", tvalid, 1'b0);
      read_expect(REG_ID, ID_VALUE, RESP_OKAY);
      read_expect(REG_SCRATCH, '0, RESP_OKAY);
      read_expect(REG_STREAM_STATUS, status_word(1'b0, 1'b1, 8'd0), RESP_OKAY);
      end_test("reset_id", e);
   endtask

   task automatic scratch_strobes();
      int    e;
      data_t val;
      e = errors;
      scratch_model = '0;
      for (int s = 0; s < 16; s++) begin
         data_seed = lcg_next(data_seed);
         val       = data_seed;
         for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
               scratch_model[b*8 +: 8] = val[b*8 +: 8];
            end
         end
         write_expect(REG_SCRATCH, val, strb_t'(s), RESP_OKAY);
         read_expect(REG_SCRATCH, scratch_model, RESP_OKAY);
      end
      write_expect(REG_CTRL, 32'hffff_ffff, 4'hf, RESP_OKAY);
      read_expect(REG_CTRL, 32'h0000_0001, RESP_OKAY);
      write_expect(REG_CTRL, 32'hffff_fffe, 4'hf, RESP_OKAY);
      read_expect(REG_CTRL, '0, RESP_OKAY);
      end_test("scratch_strobes", e);
   endtask

   task automatic unmapped_address();
      int e;
      e = errors;
      read_expect(UNMAPPED_REG, '0, RESP_SLVERR);
      write_expect(UNMAPPED_REG, 32'hdead_beef, 4'hf, RESP_SLVERR);
      read_expect(REG_SCRATCH, scratch_model, RESP_OKAY);
      read_expect(REG_CTRL, '0, RESP_OKAY);
      read_expect(REG_ID, ID_VALUE, RESP_OKAY);
      end_test("unmapped", e);
   endtask

   task automatic stream_order();
      int    e;
      data_t val;
      data_t sent_data[$];
      logic  sent_last[$];
      e = errors;
      rx_data.delete();
      rx_last.delete();
      rdy_mode = 1;
      for (int i = 0; i < 8; i++) begin
         if (i == 0 || i == 4) begin
            write_expect(REG_CTRL, (i == 0) ? 32'h1 : 32'h0, 4'h1, RESP_OKAY);
         end
         data_seed = lcg_next(data_seed);
         val       = data_seed;
         write_expect(REG_STREAM_DATA, val, 4'hf, RESP_OKAY);
         sent_data.push_back(val);
         sent_last.push_back(i < 4);
      end
      while (rx_data.size() < sent_data.size()) @(negedge aximm);
      for (int i = 0; i < sent_data.size(); i++) begin
         check_data($sformatf("stream word %0d", i), rx_data[i], sent_data[i]);
         check_flag($sformatf("last flag of word %0d", i), rx_last[i], sent_last[i]);
      end
      read_expect(REG_STREAM_STATUS, status_word(1'b0, 1'b1, 8'd0), RESP_OKAY);
      rdy_mode = 0;
      end_test("stream_order", e);
   endtask

   task automatic overflow_drop();
      int    e;
      data_t val;
      data_t sent_data[$];
      e = errors;
      rx_data.delete();
      rx_last.delete();
      rdy_mode = 0;
      for (int i = 0; i < 6; i++) begin
         data_seed = lcg_next(data_seed);
         val       = data_seed;
         write_expect(REG_STREAM_DATA, val, 4'hf, RESP_OKAY);
         sent_data.push_back(val);
      end
      read_expect(REG_STREAM_STATUS, status_word(1'b1, 1'b0, 8'(FIFO_DEPTH)), RESP_OKAY);
      read_expect(REG_STREAM_STATUS, status_word(1'b0, 1'b0, 8'(FIFO_DEPTH)), RESP_OKAY);
      rdy_mode = 2;
      while (rx_data.size() < FIFO_DEPTH) @(negedge aximm);
      read_expect(REG_STREAM_STATUS, status_word(1'b0, 1'b1, 8'd0), RESP_OKAY);
      check_data("words drained", data_t'(rx_data.size()), data_t'(FIFO_DEPTH));
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         check_data($sformatf("drained word %0d", i), rx_data[i], sent_data[i]);
      end
      rdy_mode = 0;
      end_test("overflow", e);
   endtask

   // stream sink that counts a word as taken when tvalid meets the tready driven here
   initial begin
      tready = 1'b0;
      forever begin
         @(negedge aximm);
         if (rdy_mode == 1) begin
            rdy_seed = lcg_next(rdy_seed);
            tready   = (rdy_seed[31:30] != 2'b00);
         end else begin
            tready = (rdy_mode == 2);
         end
         if (tvalid && tready) begin
            rx_data.push_back(tdata);
            rx_last.push_back(tlast);
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      rst     = 1'b1;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (2) @(posedge aximm);
      @(negedge aximm);
      rst = 1'b0;
      reset_and_id();
      scratch_strobes();
      unmapped_address();
      stream_order();
      overflow_drop();
      $display("tests run %0d, tests failed %0d, checks failed %0d", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
common/regstream_pkg.sv
common/reg_bus_if.sv
common/issue_if.sv
verilog/axi_lite_slave.sv
verilog/reg_bank.sv
verilog/stream_issue.sv
verilog/axi_reg_stream_top.sv
test/tb_axi_reg_stream.sv

/* verilog/axi_lite_slave.sv */
`timescale 1ns/1ps

module axi_lite_slave import regstream_pkg::*; #(
   parameter int ADDR_WIDTH = 12
) (
   input  logic                  aximm,
   input  logic                  rst,
   input  logic [ADDR_WIDTH-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  data_t                 wdata,
   input  strb_t                 wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   output logic                  bvalid,
   output resp_e                 bresp,
   input  logic                  bready,
   input  logic [ADDR_WIDTH-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output logic                  rvalid,
   output data_t                 rdata,
   output resp_e                 rresp,
   input  logic                  rready,
   reg_bus_if.server             bus
);

   logic                  aw_en;
   logic                  wr_go;
   logic                  rd_go;
   logic [ADDR_WIDTH-3:0] awaddr_r;
   logic [ADDR_WIDTH-3:0] araddr_r;

   assign wr_go = awvalid && wvalid && aw_en && !awready;
   // a write starting on the same edge wins, so wren and rden never overlap
   assign rd_go = arvalid && !arready && !rvalid && !wr_go;

   always_ff @(posedge aximm) begin
      if (rst) begin
         aw_en   <= 1'b1;
         awready <= 1'b0;
         wready  <= 1'b0;
      end else begin
         awready <= wr_go;
         wready  <= wr_go;
         if (wr_go) begin
            aw_en <= 1'b0;  // held off until the response is taken
         end else if (bvalid && bready) begin
            aw_en <= 1'b1;
         end
      end
   end

   always_ff @(posedge aximm) begin
      if (wr_go) begin
         awaddr_r <= awaddr[ADDR_WIDTH-1:2];
      end
   end

   assign bus.wren    = awready && awvalid && wready && wvalid;
   assign bus.wreg_no = awaddr_r;
   assign bus.wdata   = wdata;
   assign bus.wstrb   = wstrb;

   always_ff @(posedge aximm) begin
      if (rst) begin
         bvalid <= 1'b0;
      end else if (bus.wren) begin
         bvalid <= 1'b1;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   always_ff @(posedge aximm) begin
      if (bus.wren) begin
         bresp <= bus.err ? RESP_SLVERR : RESP_OKAY;
      end
   end

   always_ff @(posedge aximm) begin
      if (rst) begin
         arready <= 1'b0;
      end else begin
         arready <= rd_go;
      end
   end

   always_ff @(posedge aximm) begin
      if (rd_go) begin
         araddr_r <= araddr[ADDR_WIDTH-1:2];
      end
   end

   assign bus.rden    = arready && arvalid;
   assign bus.rreg_no = araddr_r;

   always_ff @(posedge aximm) begin
      if (rst) begin
         rvalid <= 1'b0;
      end else if (bus.rden) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge aximm) begin
      if (bus.rden) begin
         rdata <= bus.rdata;
         rresp <= bus.err ? RESP_SLVERR : RESP_OKAY;
      end
   end

endmodule

/* verilog/axi_reg_stream_top.sv */
`timescale 1ns/1ps

module axi_reg_stream_top import regstream_pkg::*; #(
   parameter int ADDR_WIDTH = 12,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                  aximm,
   input  logic                  rst,
   input  logic [ADDR_WIDTH-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  data_t                 wdata,
   input  strb_t                 wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   output logic                  bvalid,
   output resp_e                 bresp,
   input  logic                  bready,
   input  logic [ADDR_WIDTH-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output logic                  rvalid,
   output data_t                 rdata,
   output resp_e                 rresp,
   input  logic                  rready,
   output logic                  tvalid,
   output data_t                 tdata,
   output logic                  tlast,
   input  logic                  tready
);

   reg_bus_if #(.REG_BITS(ADDR_WIDTH - 2)) bus0 ();
   issue_if issue0 ();

   axi_lite_slave #(.ADDR_WIDTH(ADDR_WIDTH)) slave0 (
      .aximm   (aximm),
      .rst     (rst),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bvalid  (bvalid),
      .bresp   (bresp),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rvalid  (rvalid),
      .rdata   (rdata),
      .rresp   (rresp),
      .rready  (rready),
      .bus     (bus0.server)
   );

   reg_bank bank0 (
      .aximm (aximm),
      .rst   (rst),
      .bus   (bus0.client),
      .issue (issue0.bank)
   );

   stream_issue #(.FIFO_DEPTH(FIFO_DEPTH)) issue_blk0 (
      .aximm  (aximm),
      .rst    (rst),
      .issue  (issue0.issuer),
      .tvalid (tvalid),
      .tdata  (tdata),
      .tlast  (tlast),
      .tready (tready)
   );

endmodule

/* verilog/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank import regstream_pkg::*; (
   input  logic      aximm,
   input  logic      rst,
   reg_bus_if.client bus,
   issue_if.bank     issue
);

   data_t    scratch;
   logic     last_en;
   reg_sel_e rsel;
   data_t    rd_val;

   always_ff @(posedge aximm) begin
      if (rst) begin
         scratch <= '0;
         last_en <= 1'b0;
      end else begin
         if (bus.wr_hit(REG_SCRATCH)) begin
            scratch <= bus.merge_bytes(scratch);
         end
         if (bus.wr_hit(REG_CTRL) && bus.wstrb[0]) begin
            last_en <= bus.wdata[0];
         end
      end
   end

   // each word written to the data register goes to the issuer with the current last flag
   assign issue.push      = bus.wr_hit(REG_STREAM_DATA);
   assign issue.push_data = bus.wdata;
   assign issue.push_last = last_en;
   assign issue.status_rd = bus.rd_hit(REG_STREAM_STATUS);

   always_comb begin
      rsel   = reg_sel_e'(bus.rreg_no[2:0]);
      rd_val = '0;
      if (bus.mapped(bus.rreg_no)) begin
         case (rsel)
            REG_ID:            rd_val = ID_VALUE;
            REG_SCRATCH:       rd_val = scratch;
            REG_CTRL:          rd_val = {31'd0, last_en};
            REG_STREAM_STATUS: rd_val = {16'd0, issue.level, 6'd0, issue.empty, issue.failed};
            default:           rd_val = '0;  // data register is write-only
         endcase
      end
   end

   assign bus.rdata = rd_val;
   assign bus.err   = (bus.wren && !bus.mapped(bus.wreg_no)) ||
                      (bus.rden && !bus.mapped(bus.rreg_no));

endmodule

/* verilog/stream_issue.sv */
`timescale 1ns/1ps

module stream_issue import regstream_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic    aximm,
   input  logic    rst,
   issue_if.issuer issue,
   output logic    tvalid,
   output data_t   tdata,
   output logic    tlast,
   input  logic    tready
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   data_t            mem_data [FIFO_DEPTH];
   logic             mem_last [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;    // words held including the output register
   logic [CNT_W-1:0] mem_cnt;
   logic             accept;
   logic             drop;
   logic             pop;
   logic             load;
   logic             from_mem;
   logic             bypass;

   assign accept   = issue.push && (count != CNT_W'(FIFO_DEPTH));
   assign drop     = issue.push && !accept;
   assign pop      = tvalid && tready;
   assign load     = !tvalid || tready;  // output register is free at the next edge
   assign mem_cnt  = count - CNT_W'(tvalid);
   assign from_mem = load && (mem_cnt != '0);
   // with nothing queued, a new word goes straight to the output register
   assign bypass   = load && (mem_cnt == '0) && accept;

   always_ff @(posedge aximm) begin
      if (rst) begin
         tvalid       <= 1'b0;
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         issue.failed <= 1'b0;
      end else begin
         if (load) begin
            tvalid <= from_mem || bypass;
         end
         if (accept && !bypass) begin
            wr_ptr <= wr_ptr + PTR_W'(1);
         end
         if (from_mem) begin
            rd_ptr <= rd_ptr + PTR_W'(1);
         end
         count <= count + CNT_W'(accept) - CNT_W'(pop);
         if (drop) begin
            issue.failed <= 1'b1;  // a drop beats a clearing status read
         end else if (issue.status_rd) begin
            issue.failed <= 1'b0;
         end
      end
   end

   always_ff @(posedge aximm) begin
      if (accept && !bypass) begin
         mem_data[wr_ptr] <= issue.push_data;
         mem_last[wr_ptr] <= issue.push_last;
      end
      if (from_mem) begin
         tdata <= mem_data[rd_ptr];
         tlast <= mem_last[rd_ptr];
      end else if (bypass) begin
         tdata <= issue.push_data;
         tlast <= issue.push_last;
      end
   end

   assign issue.empty = (count == '0);
   assign issue.level = level_t'(count);

endmodule
